// File: design/edge_config.svh
`ifndef EDGE_CONFIG_SVH
`define EDGE_CONFIG_SVH

// ===============================================
// Write edge sizing
// ===============================================

// Width of a cache-line address
`define EDGE_ADDR_W 32

// Width of one beat of write data
`define EDGE_DATA_W 64

// Beats in the largest multi-line write packet
`define EDGE_MAX_BEATS 4

// Packet entries in the write heap, one entry holds a whole packet
`define EDGE_HEAP_ENTRIES 8

// Almost-full is wanted while free heap entries are at or below this count
// The slack absorbs the packet that may start while almost-full is registered
`define EDGE_ALMOST_FULL_SLOTS 2

`endif

// File: design/edge_pkg.sv
`include "edge_config.svh"

package edge_pkg;

    // Cache-line address as seen on the AFU and on the memory side
    typedef logic [`EDGE_ADDR_W-1:0] addr_t;

    // One beat of write data
    typedef logic [`EDGE_DATA_W-1:0] data_t;

    // Packet length encoded as the number of beats minus one
    typedef logic [$clog2(`EDGE_MAX_BEATS)-1:0] cl_len_t;

    // Index of a beat inside its packet
    typedef logic [$clog2(`EDGE_MAX_BEATS)-1:0] beat_num_t;

    // Index of a heap entry
    typedef logic [$clog2(`EDGE_HEAP_ENTRIES)-1:0] heap_idx_t;

    // Entry count with one extra bit so a completely free heap fits
    typedef logic [$clog2(`EDGE_HEAP_ENTRIES):0] heap_count_t;

    // Replay machine for the four-phase handshake toward memory
    typedef enum logic [1:0] {
        replay_idle,
        replay_raise,
        replay_wait_ack_high,
        replay_wait_ack_low
    } replay_state_t;

endpackage

// File: design/write_packet_tracker.sv
`timescale 1ns/100ps
`include "edge_config.svh"

module write_packet_tracker
(
    input  logic                  clk,
    input  logic                  reset,

    // AFU write channel
    input  logic                  wr_valid,
    input  logic                  wr_sop,
    input  edge_pkg::cl_len_t     wr_cl_len,
    input  edge_pkg::addr_t       wr_addr,
    input  edge_pkg::data_t       wr_data,
    output logic                  almost_full,

    // Heap allocation and occupancy
    input  edge_pkg::heap_count_t free_count,
    input  edge_pkg::heap_idx_t   alloc_idx,
    input  logic                  not_full,
    output logic                  alloc,

    // One heap write per accepted beat
    output logic                  wen,
    output edge_pkg::heap_idx_t   widx,
    output edge_pkg::beat_num_t   wbeat,
    output edge_pkg::data_t       wdata,

    // Descriptor of a packet whose last beat is stored
    output logic                  push,
    output edge_pkg::addr_t       push_addr,
    output edge_pkg::cl_len_t     push_cl_len,
    output edge_pkg::heap_idx_t   push_idx
);

    import edge_pkg::*;

    // Header of the start beat, kept for the beats that follow it
    addr_t     sop_addr;
    cl_len_t   sop_cl_len;
    heap_idx_t sop_idx;

    // Beat counter and packet state
    beat_num_t next_beat;
    logic      packet_active;
    logic      active_next;
    logic      sticky_full;
    logic      af_wanted;

    // Canonical header of the beat at the port
    addr_t     canon_addr;
    cl_len_t   canon_cl_len;
    heap_idx_t canon_idx;
    beat_num_t canon_beat;
    logic      last_beat;

    // Entry of the registered beat, shared by the write and the push
    heap_idx_t beat_idx;

    // ===============================================
    // Header recovery
    // ===============================================

    // Address and length are don't-care on later beats
    // The start beat takes the entry the heap offers this cycle
    always_comb
    begin
        if (wr_sop)
        begin
            canon_addr   = wr_addr;
            canon_cl_len = wr_cl_len;
            canon_idx    = alloc_idx;
            canon_beat   = '0;
        end
        else
        begin
            canon_addr   = sop_addr;
            canon_cl_len = sop_cl_len;
            canon_idx    = sop_idx;
            canon_beat   = next_beat;
        end
    end

    assign last_beat = (canon_beat == beat_num_t'(canon_cl_len));
    assign alloc = wr_valid && wr_sop;

    // A packet is still open after this cycle unless its last beat arrives now
    assign active_next = wr_valid ? !last_beat : packet_active;

    always_ff @(posedge clk)
    begin
        if (wr_valid && wr_sop)
        begin
            sop_addr   <= wr_addr;
            sop_cl_len <= wr_cl_len;
            sop_idx    <= alloc_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            next_beat     <= '0;
            packet_active <= 1'b0;
        end
        else
        begin
            packet_active <= active_next;
            if (wr_valid)
            begin
                next_beat <= last_beat ? beat_num_t'(0) : canon_beat + 1'b1;
            end
        end
    end

    // ===============================================
    // Beat registration toward the heap
    // ===============================================

    // The push goes out with the last beat's write so the data is stored
    // by the time the descriptor becomes visible
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wen  <= 1'b0;
            push <= 1'b0;
        end
        else
        begin
            wen  <= wr_valid;
            push <= wr_valid && last_beat;
        end
    end

    always_ff @(posedge clk)
    begin
        beat_idx    <= canon_idx;
        wbeat       <= canon_beat;
        wdata       <= wr_data;
        push_addr   <= canon_addr;
        push_cl_len <= canon_cl_len;
    end

    assign widx     = beat_idx;
    assign push_idx = beat_idx;

    // ===============================================
    // Almost-full toward the AFU
    // ===============================================

    assign af_wanted = (free_count <= heap_count_t'(`EDGE_ALMOST_FULL_SLOTS)) || !not_full;

    // Almost-full may not rise inside a packet because its remaining beats
    // must still land in the heap
    // Once set while idle, the sticky bit holds the request through the
    // next packet until the heap drains again
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            almost_full <= 1'b1;
            sticky_full <= 1'b0;
        end
        else
        begin
            almost_full <= af_wanted && (!active_next || sticky_full);
            if (!af_wanted)
            begin
                sticky_full <= 1'b0;
            end
            else if (!active_next)
            begin
                sticky_full <= 1'b1;
            end
        end
    end

endmodule

// File: design/write_heap.sv
`timescale 1ns/100ps
`include "edge_config.svh"

module write_heap
(
    input  logic                  clk,
    input  logic                  reset,

    // Entry allocation from the tracker
    input  logic                  alloc,
    output edge_pkg::heap_idx_t   alloc_idx,
    output logic                  not_full,
    output edge_pkg::heap_count_t free_count,

    // Beat writes
    input  logic                  wen,
    input  edge_pkg::heap_idx_t   widx,
    input  edge_pkg::beat_num_t   wbeat,
    input  edge_pkg::data_t       wdata,

    // Completed packets enter the descriptor queue
    input  logic                  push,
    input  edge_pkg::addr_t       push_addr,
    input  edge_pkg::cl_len_t     push_cl_len,
    input  edge_pkg::heap_idx_t   push_idx,

    // Head of the descriptor queue toward the replay side
    output logic                  desc_valid,
    output edge_pkg::addr_t       desc_addr,
    output edge_pkg::cl_len_t     desc_cl_len,
    output edge_pkg::heap_idx_t   desc_idx,
    input  logic                  pop,

    // Combinational read port
    input  edge_pkg::heap_idx_t   rd_idx,
    input  edge_pkg::beat_num_t   rd_beat,
    output edge_pkg::data_t       rd_data,

    // Entry release after replay
    input  logic                  free,
    input  edge_pkg::heap_idx_t   free_idx
);

    import edge_pkg::*;

    // Pointers of both queues wrap on their own since the entry count
    // is a power of two

    heap_idx_t   free_list [`EDGE_HEAP_ENTRIES];
    heap_idx_t   free_head;
    heap_idx_t   free_tail;
    heap_count_t free_cnt;

    data_t       store [`EDGE_HEAP_ENTRIES][`EDGE_MAX_BEATS];

    addr_t       dq_addr [`EDGE_HEAP_ENTRIES];
    cl_len_t     dq_cl_len [`EDGE_HEAP_ENTRIES];
    heap_idx_t   dq_idx [`EDGE_HEAP_ENTRIES];
    heap_idx_t   dq_head;
    heap_idx_t   dq_tail;
    heap_count_t dq_cnt;

    // ===============================================
    // Free list of entry indices
    // ===============================================

    // Every entry starts out free, listed in index order
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `EDGE_HEAP_ENTRIES; i++)
            begin
                free_list[i] <= heap_idx_t'(i);
            end
            free_head <= '0;
            free_tail <= '0;
            free_cnt  <= heap_count_t'(`EDGE_HEAP_ENTRIES);
        end
        else
        begin
            if (alloc)
            begin
                free_head <= free_head + 1'b1;
            end
            if (free)
            begin
                free_list[free_tail] <= free_idx;
                free_tail <= free_tail + 1'b1;
            end
            case ({alloc, free})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    assign alloc_idx  = free_list[free_head];
    assign not_full   = (free_cnt != '0);
    assign free_count = free_cnt;

    // ===============================================
    // Data store, one slot per beat of each entry
    // ===============================================

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            store[widx][wbeat] <= wdata;
        end
    end

    assign rd_data = store[rd_idx][rd_beat];

    // ===============================================
    // Descriptor queue in completion order
    // ===============================================

    // It never overflows because each queued packet owns a heap entry
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            dq_addr[dq_tail]   <= push_addr;
            dq_cl_len[dq_tail] <= push_cl_len;
            dq_idx[dq_tail]    <= push_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dq_head <= '0;
            dq_tail <= '0;
            dq_cnt  <= '0;
        end
        else
        begin
            if (push)
            begin
                dq_tail <= dq_tail + 1'b1;
            end
            if (pop)
            begin
                dq_head <= dq_head + 1'b1;
            end
            case ({push, pop})
                2'b10:   dq_cnt <= dq_cnt + 1'b1;
                2'b01:   dq_cnt <= dq_cnt - 1'b1;
                default: dq_cnt <= dq_cnt;
            endcase
        end
    end

    assign desc_valid  = (dq_cnt != '0);
    assign desc_addr   = dq_addr[dq_head];
    assign desc_cl_len = dq_cl_len[dq_head];
    assign desc_idx    = dq_idx[dq_head];

endmodule

// File: design/write_replay.sv
`timescale 1ns/100ps
`include "edge_config.svh"

module write_replay
(
    input  logic                clk,
    input  logic                reset,

    // Head descriptor from the heap
    input  logic                desc_valid,
    input  edge_pkg::addr_t     desc_addr,
    input  edge_pkg::cl_len_t   desc_cl_len,
    input  edge_pkg::heap_idx_t desc_idx,
    output logic                pop,

    // Heap read of the beat being replayed
    output edge_pkg::heap_idx_t rd_idx,
    output edge_pkg::beat_num_t rd_beat,
    input  edge_pkg::data_t     rd_data,

    // Entry release
    output logic                free,
    output edge_pkg::heap_idx_t free_idx,

    // Memory side, four-phase req/ack
    output logic                out_req,
    input  logic                out_ack,
    output edge_pkg::addr_t     out_addr,
    output edge_pkg::beat_num_t out_beat,
    output edge_pkg::cl_len_t   out_cl_len,
    output edge_pkg::data_t     out_data
);

    import edge_pkg::*;

    replay_state_t state;
    beat_num_t     beat;
    logic          last_beat;
    logic          done;

    assign last_beat = (beat == beat_num_t'(desc_cl_len));

    // ===============================================
    // Handshake machine
    // ===============================================

    // The raise state gives the out fields one cycle to settle before
    // out_req rises
    // A new beat starts only after out_ack has fallen
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= replay_idle;
            beat    <= '0;
            out_req <= 1'b0;
        end
        else
        begin
            case (state)
                replay_idle:
                begin
                    if (desc_valid)
                    begin
                        beat  <= '0;
                        state <= replay_raise;
                    end
                end
                replay_raise:
                begin
                    out_req <= 1'b1;
                    state   <= replay_wait_ack_high;
                end
                replay_wait_ack_high:
                begin
                    if (out_ack)
                    begin
                        out_req <= 1'b0;
                        state   <= replay_wait_ack_low;
                    end
                end
                replay_wait_ack_low:
                begin
                    if (!out_ack)
                    begin
                        if (last_beat)
                        begin
                            state <= replay_idle;
                        end
                        else
                        begin
                            beat  <= beat + 1'b1;
                            state <= replay_raise;
                        end
                    end
                end
                default:
                begin
                    state <= replay_idle;
                end
            endcase
        end
    end

    // The packet is finished when the last beat's ack falls
    assign done = (state == replay_wait_ack_low) && !out_ack && last_beat;
    assign pop  = done;
    assign free = done;
    assign free_idx = desc_idx;

    // The head descriptor and its entry stay put until the pop
    // so the out fields hold steady across the handshake
    assign rd_idx     = desc_idx;
    assign rd_beat    = beat;
    assign out_addr   = desc_addr;
    assign out_cl_len = desc_cl_len;
    assign out_beat   = beat;
    assign out_data   = rd_data;

endmodule

// File: design/write_edge_top.sv
`timescale 1ns/100ps
`include "edge_config.svh"

module write_edge_top
(
    input  logic                clk,
    input  logic                reset,

    // AFU write channel
    input  logic                wr_valid,
    input  logic                wr_sop,
    input  edge_pkg::cl_len_t   wr_cl_len,
    input  edge_pkg::addr_t     wr_addr,
    input  edge_pkg::data_t     wr_data,
    output logic                almost_full,

    // Memory side
    output logic                out_req,
    input  logic                out_ack,
    output edge_pkg::addr_t     out_addr,
    output edge_pkg::beat_num_t out_beat,
    output edge_pkg::cl_len_t   out_cl_len,
    output edge_pkg::data_t     out_data
);

    import edge_pkg::*;

    // Allocation and occupancy
    logic        alloc;
    heap_idx_t   alloc_idx;
    logic        not_full;
    heap_count_t free_count;

    // Beat writes and completed packets
    logic        wen;
    heap_idx_t   widx;
    beat_num_t   wbeat;
    data_t       wdata;
    logic        push;
    addr_t       push_addr;
    cl_len_t     push_cl_len;
    heap_idx_t   push_idx;

    // Replay side of the heap
    logic        desc_valid;
    addr_t       desc_addr;
    cl_len_t     desc_cl_len;
    heap_idx_t   desc_idx;
    logic        pop;
    heap_idx_t   rd_idx;
    beat_num_t   rd_beat;
    data_t       rd_data;
    logic        free;
    heap_idx_t   free_idx;

    write_packet_tracker u_tracker
    (
        .clk, .reset,
        .wr_valid, .wr_sop, .wr_cl_len, .wr_addr, .wr_data, .almost_full,
        .free_count, .alloc_idx, .not_full, .alloc,
        .wen, .widx, .wbeat, .wdata,
        .push, .push_addr, .push_cl_len, .push_idx
    );

    write_heap u_heap
    (
        .clk, .reset,
        .alloc, .alloc_idx, .not_full, .free_count,
        .wen, .widx, .wbeat, .wdata,
        .push, .push_addr, .push_cl_len, .push_idx,
        .desc_valid, .desc_addr, .desc_cl_len, .desc_idx, .pop,
        .rd_idx, .rd_beat, .rd_data,
        .free, .free_idx
    );

    write_replay u_replay
    (
        .clk, .reset,
        .desc_valid, .desc_addr, .desc_cl_len, .desc_idx, .pop,
        .rd_idx, .rd_beat, .rd_data,
        .free, .free_idx,
        .out_req, .out_ack, .out_addr, .out_beat, .out_cl_len, .out_data
    );

endmodule

// File: test/tb_afu_tasks.svh
`ifndef TB_AFU_TASKS_SVH
`define TB_AFU_TASKS_SVH

// ===============================================
// Random source, AFU driver and memory responder
// ===============================================

// One step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Sends one packet, starting only while almost_full is low
// With scramble set, later beats carry a wrong header and gaps may appear
// Called and left on a falling edge
task automatic send_packet(input addr_t addr, input cl_len_t cl_len, input logic scramble);
    int    waited;
    data_t data;
    waited = 0;
    if (timed_out)
    begin
        return;
    end
    while (almost_full && !timed_out)
    begin
        if (waited >= AF_WAIT_LIMIT)
        begin
            note_timeout("almost_full to fall before a new packet");
        end
        else
        begin
            waited++;
            @(negedge clk);
        end
    end
    if (timed_out)
    begin
        return;
    end
    for (int b = 0; b <= int'(cl_len); b++)
    begin
        stim_rng = xorshift32(stim_rng);
        data[63:32] = stim_rng;
        stim_rng = xorshift32(stim_rng);
        data[31:0] = stim_rng;
        wr_valid = 1'b1;
        wr_sop   = (b == 0);
        wr_data  = data;
        if (b == 0 || !scramble)
        begin
            wr_addr   = addr;
            wr_cl_len = cl_len;
        end
        else
        begin
            // The header of a later beat is don't-care, so make it wrong
            wr_addr   = ~addr;
            wr_cl_len = ~cl_len;
        end
        // Open from the start beat until the last beat is on the port
        pkt_open = (b != int'(cl_len));
        record_beat(addr, beat_num_t'(b), cl_len, data);
        @(negedge clk);
        if (scramble && b != int'(cl_len))
        begin
            stim_rng = xorshift32(stim_rng);
            if (stim_rng[0])
            begin
                wr_valid = 1'b0;
                wr_sop   = 1'b0;
                @(negedge clk);
            end
        end
    end
    wr_valid = 1'b0;
    wr_sop   = 1'b0;
endtask

// One falling edge of the four-phase responder on the memory side
task automatic respond_cycle();
    if (reset)
    begin
        out_ack   = 1'b0;
        ack_delay = 0;
    end
    else if (out_ack)
    begin
        // Drop the ack once the request is gone
        if (!out_req)
        begin
            out_ack = 1'b0;
        end
    end
    else if (out_req && !ack_stall)
    begin
        if (ack_delay == 0)
        begin
            out_ack   = 1'b1;
            ack_rng   = xorshift32(ack_rng);
            ack_delay = int'(ack_rng[1:0]);
        end
        else
        begin
            ack_delay--;
        end
    end
endtask

`endif

// File: test/tb_write_edge.sv
`timescale 1ns/100ps
`include "edge_config.svh"

module tb_write_edge;

    import edge_pkg::*;

    // Bounds of the wait loops, in clock cycles
    localparam int AF_WAIT_LIMIT      = 200;
    localparam int DRAIN_LIMIT        = 5000;
    localparam int STALL_PACKET_LIMIT = `EDGE_HEAP_ENTRIES + 4;
    localparam int RANDOM_PACKETS     = 40;

    logic      clk = 1'b0;
    logic      reset;
    logic      wr_valid;
    logic      wr_sop;
    cl_len_t   wr_cl_len;
    addr_t     wr_addr;
    data_t     wr_data;
    logic      almost_full;
    logic      out_req;
    logic      out_ack;
    addr_t     out_addr;
    beat_num_t out_beat;
    cl_len_t   out_cl_len;
    data_t     out_data;

    // Stimulus and responder state
    logic [31:0] stim_rng = 32'd2;
    logic [31:0] ack_rng = 32'd2;
    int          ack_delay = 0;
    logic        ack_stall = 1'b0;
    logic        pkt_open = 1'b0;
    logic        timed_out = 1'b0;
    logic        rst_q = 1'b0;
    logic        req_q = 1'b0;

    // Scoreboard of expected beats in send order
    // Its head is copied to exp_*
    addr_t     sb_addr [$];
    beat_num_t sb_beat [$];
    cl_len_t   sb_len [$];
    data_t     sb_data [$];
    int        sb_size = 0;
    addr_t     exp_addr;
    beat_num_t exp_beat;
    cl_len_t   exp_len;
    data_t     exp_data;

    int value_errors = 0;
    int protocol_errors = 0;
    int other_errors = 0;
    int beats_sent = 0;
    int beats_seen = 0;

    `include "tb_afu_tasks.svh"

    always #10 clk = ~clk;

    write_edge_top DUT
    (
        .clk, .reset,
        .wr_valid, .wr_sop, .wr_cl_len, .wr_addr, .wr_data, .almost_full,
        .out_req, .out_ack, .out_addr, .out_beat, .out_cl_len, .out_data
    );

    // ===============================================
    // Scoreboard
    // ===============================================

    function automatic void refresh_head();
        sb_size = sb_addr.size();
        if (sb_size != 0)
        begin
            exp_addr = sb_addr[0];
            exp_beat = sb_beat[0];
            exp_len  = sb_len[0];
            exp_data = sb_data[0];
        end
    endfunction

    function automatic void record_beat(addr_t a, beat_num_t b, cl_len_t l, data_t d);
        sb_addr.push_back(a);
        sb_beat.push_back(b);
        sb_len.push_back(l);
        sb_data.push_back(d);
        beats_sent++;
        refresh_head();
    endfunction

    task automatic note_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        other_errors++;
        timed_out = 1'b1;
    endtask

    // Waits until every sent beat has been requested and out_req has fallen
    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        while ((sb_size != 0 || out_req) && !timed_out)
        begin
            if (waited >= DRAIN_LIMIT)
            begin
                note_timeout(what);
            end
            else
            begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    always @(negedge clk)
    begin
        respond_cycle();
    end

    // A beat is taken from the scoreboard where out_req rises
    // The assertions sample the head before this pop
    always @(posedge clk)
    begin
        rst_q <= reset;
        req_q <= out_req;
        if (!reset && out_req && !req_q && sb_size != 0)
        begin
            void'(sb_addr.pop_front());
            void'(sb_beat.pop_front());
            void'(sb_len.pop_front());
            void'(sb_data.pop_front());
            beats_seen++;
            refresh_head();
        end
    end

    // ===============================================
    // Assertions
    // ===============================================

    // During reset and one cycle after it
    reset_state: assert property (@(posedge clk) rst_q |-> almost_full && !out_req)
    else
    begin
        protocol_errors++;
        $display("** Error: almost_full = %h, out_req = %h after reset, expected 1 and 0",
                 $sampled(almost_full), $sampled(out_req));
    end

    beat_expected: assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) |-> sb_size != 0)
    else
    begin
        protocol_errors++;
        $display("out_req rose although no beat was left to replay");
    end

    addr_matches: assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) && sb_size != 0 |-> out_addr == exp_addr)
    else
    begin
        value_errors++;
        $display("** Error: out_addr = %h, expected %h", $sampled(out_addr), $sampled(exp_addr));
    end

    beat_matches: assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) && sb_size != 0 |-> out_beat == exp_beat)
    else
    begin
        value_errors++;
        $display("** Error: out_beat = %h, expected %h", $sampled(out_beat), $sampled(exp_beat));
    end

    len_matches: assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) && sb_size != 0 |-> out_cl_len == exp_len)
    else
    begin
        value_errors++;
        $display("** Error: out_cl_len = %h, expected %h",
                 $sampled(out_cl_len), $sampled(exp_len));
    end

    data_matches: assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) && sb_size != 0 |-> out_data == exp_data)
    else
    begin
        value_errors++;
        $display("** Error: out_data = %h, expected %h", $sampled(out_data), $sampled(exp_data));
    end

    // Four-phase rules of the memory side
    fields_stable: assert property (@(posedge clk) disable iff (reset)
        out_req && $past(out_req) |->
            $stable(out_addr) && $stable(out_beat) && $stable(out_cl_len) && $stable(out_data))
    else
    begin
        protocol_errors++;
        $display("An out field changed while out_req was high");
    end

    // The ack seen on the edge where out_req went high must already be low
    req_rises_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) |-> !$past(out_ack))
    else
    begin
        protocol_errors++;
        $display("out_req rose while out_ack was still high");
    end

    req_falls_on_ack: assert property (@(posedge clk) disable iff (reset)
        $fell(out_req) |-> $past(out_ack))
    else
    begin
        protocol_errors++;
        $display("out_req fell before out_ack rose");
    end

    // Almost-full may not rise inside a packet that began while it was low
    af_outside_packet: assert property (@(posedge clk) disable iff (reset)
        $rose(almost_full) |-> !$past(pkt_open))
    else
    begin
        protocol_errors++;
        $display("almost_full rose inside a packet that started while it was low");
    end

    // ===============================================
    // Test sequence
    // ===============================================

    initial
    begin
        addr_t   addr;
        cl_len_t len;
        int      sent;
        int      total;
        reset     = 1'b1;
        wr_valid  = 1'b0;
        wr_sop    = 1'b0;
        wr_cl_len = '0;
        wr_addr   = '0;
        wr_data   = '0;
        out_ack   = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Directed packets of one beat and then of four beats with wrong later headers
        send_packet(32'h0000_1040, 2'd0, 1'b0);
        wait_drained("the single-beat packet");
        send_packet(32'h0002_2080, 2'd3, 1'b1);
        wait_drained("the four-beat packet");

        for (int p = 0; p < RANDOM_PACKETS; p++)
        begin
            stim_rng = xorshift32(stim_rng);
            addr = stim_rng;
            stim_rng = xorshift32(stim_rng);
            len = cl_len_t'(stim_rng[1:0]);
            send_packet(addr, len, 1'b1);
        end
        wait_drained("the random packets");

        // Stall the acks so the heap fills and almost_full must rise
        ack_stall = 1'b1;
        sent = 0;
        while (!almost_full && !timed_out)
        begin
            if (sent >= STALL_PACKET_LIMIT)
            begin
                note_timeout("almost_full to rise while out_ack is stalled");
            end
            else
            begin
                stim_rng = xorshift32(stim_rng);
                addr = stim_rng;
                stim_rng = xorshift32(stim_rng);
                len = cl_len_t'(stim_rng[1:0]);
                send_packet(addr, len, 1'b1);
                sent++;
            end
        end
        repeat (10) @(negedge clk);
        @(posedge clk);
        ack_stall = 1'b0;
        wait_drained("the packets held back by the stalled out_ack");

        repeat (4) @(negedge clk);
        if (beats_seen != beats_sent)
        begin
            $display("Only %0d of %0d sent beats came out", beats_seen, beats_sent);
            other_errors++;
        end
        total = value_errors + protocol_errors + other_errors;
        $display("Errors: value %0d, protocol %0d, other %0d, total %0d (beats %0d)",
                 value_errors, protocol_errors, other_errors, total, beats_seen);
        if (total == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
+incdir+test
design/edge_pkg.sv
design/write_packet_tracker.sv
design/write_heap.sv
design/write_replay.sv
design/write_edge_top.sv
test/tb_write_edge.sv
